/* verilog.f */
+incdir+include
rtl/motor_pkg.sv
rtl/delay_tick_gen.sv
rtl/amp_enable_delay.sv
rtl/safety_check.sv
rtl/motor_channel.sv
rtl/motor_board.sv
bench/tb_motor_board.sv

/* run_sim.sh */
#!/bin/sh
# build the motor_board testbench with Verilator and run it
# exit status is 0 only when the run prints the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module tb_motor_board \
    -Mdir obj_dir -f verilog.f \
    && ./obj_dir/Vtb_motor_board | tee /dev/stderr | grep -qx "sim passed" \
    && { echo "run_sim: simulation ok"; exit 0; } \
    || { echo "run_sim: simulation not ok"; exit 1; }

/* bench/tb_motor_board.sv */
/*
 * Directed testbench for motor_board with four channels: register readback,
 * control mode, amplifier enable delay, current safety latch and its masking.
 * Inputs change on the falling edge, outputs are sampled a quarter period later.
 */
`default_nettype none
`include "motor_params.svh"

module tb_motor_board;

    localparam int NUM_CH      = 4;
    localparam int CLK_PERIOD  = 100;
    localparam int SETTLE      = CLK_PERIOD / 4;   // sample point after negedge
    // reset plus rough length of each test, in cycles
    localparam int TEST_CYCLES = 16 + 90 + 40 + 4 * `DELAY_DIV + 40 + 60 + 130;
    localparam logic [15:0] MID = 16'h8000;                    // zero current
    localparam logic [15:0] BAD = MID + `SAFETY_LIMIT + 16'd1; // just over limit

    logic                 clk;
    logic                 rst;
    logic [15:0]          reg_waddr;
    logic [31:0]          reg_wdata;
    logic                 reg_wen;
    logic [15:0]          reg_raddr;
    logic [31:0]          reg_rdata;
    logic                 ioexp_present;
    logic                 clr_safety_disable;
    logic [NUM_CH-1:0]    amp_fault;        // 1 -> amp reports no fault
    logic [NUM_CH-1:0]    cur_ctrl_error;
    logic [NUM_CH-1:0]    disable_f_error;
    logic [NUM_CH-1:0]    amp_disable;
    logic [16*NUM_CH-1:0] cur_fb;
    logic [NUM_CH-1:0]    amp_disable_pin;
    logic [NUM_CH-1:0]    force_disable_f;
    logic [NUM_CH-1:0]    cur_ctrl;
    logic [16*NUM_CH-1:0] cur_cmd;
    int                   n_checks;
    int                   n_errors;
    integer               seed;

    motor_board #(.NUM_CHANNELS(NUM_CH)) dut0 (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // watchdog at twice the expected run length
    initial begin
        #(2 * TEST_CYCLES * CLK_PERIOD);
        $display("timeout: tests still running after %0d cycles", 2 * TEST_CYCLES);
        $display("sim failed");
        $finish;
    end

    // {main, 0, channel, offset}
    function automatic logic [15:0] addr_of(input int ch, input logic [3:0] off);
        return {`MOTOR_ADDR_MAIN, 4'h0, 4'(ch), off};
    endfunction

    function automatic logic [31:0] dac_word(input logic [3:0] mode, input logic [15:0] cmd);
        return {4'h0, mode, 8'h00, cmd};
    endfunction

    // expected status word built from its field values
    function automatic logic [31:0] status_word(input logic ad, input logic [3:0] mode,
            input logic cc, input logic ce, input logic de, input logic sd,
            input logic af, input logic [15:0] cmd);
        logic fault_fb;
        fault_fb = (ad == 1'b0) && (af == 1'b0);   // enabled amp reporting a fault
        return {3'b000, ~ad, mode, 3'b000, cc, ce, de, sd, fault_fb, cmd};
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
            input logic [31:0] actual);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            $display("** Error: %s expected 0x%0h, got 0x%0h at %0t",
                     name, expected, actual, $time);
        end
    endtask

    task automatic write_reg(input logic [15:0] addr, input logic [31:0] data);
        @(negedge clk);
        reg_waddr = addr;
        reg_wdata = data;
        reg_wen   = 1'b1;
        @(negedge clk);          // taken on the posedge in between
        reg_wen   = 1'b0;
    endtask

    task automatic read_expect(input string name, input logic [15:0] addr,
            input logic [31:0] expected);
        @(negedge clk);
        reg_raddr = addr;
        #(SETTLE);               // read port is combinational
        check(name, expected, reg_rdata);
    endtask

    task automatic set_fb(input int ch, input logic [15:0] val);
        cur_fb[16*(ch-1) +: 16] = val;
    endtask

    task automatic pulse_clear();
        @(negedge clk);
        clr_safety_disable = 1'b1;
        @(negedge clk);
        clr_safety_disable = 1'b0;
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("%s: %0d errors", name, n_errors - errs_before);
    endtask

    task automatic reset_and_readback();
        int          errs;
        logic [31:0] dac_data [NUM_CH];
        logic [31:0] cfg_data [NUM_CH];
        errs = n_errors;
        for (int ch = 1; ch <= NUM_CH; ch++) begin
            read_expect("config", addr_of(ch, `MOTOR_OFF_CONFIG), `MOTOR_CONFIG_DEFAULT);
            read_expect("status", addr_of(ch, `MOTOR_OFF_STATUS),
                        status_word(1'b1, 4'h0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 16'h0));
        end
        for (int ch = 1; ch <= NUM_CH; ch++) begin
            dac_data[ch-1] = $random(seed);
            cfg_data[ch-1] = $random(seed);
            write_reg(addr_of(ch, `MOTOR_OFF_DAC_CTRL), dac_data[ch-1]);
            write_reg(addr_of(ch, `MOTOR_OFF_CONFIG), cfg_data[ch-1]);
        end
        // none of these may land in any channel
        write_reg(addr_of(NUM_CH + 1, `MOTOR_OFF_DAC_CTRL), 32'hffff_ffff);
        write_reg(addr_of(1, `MOTOR_OFF_STATUS), 32'hffff_ffff);
        write_reg(addr_of(2, 4'h3), 32'hffff_ffff);
        write_reg({4'h3, 4'h0, 4'h1, `MOTOR_OFF_CONFIG}, 32'hffff_ffff);
        write_reg({`MOTOR_ADDR_MAIN, 4'h1, 4'h2, `MOTOR_OFF_CONFIG}, 32'hffff_ffff);
        for (int ch = 1; ch <= NUM_CH; ch++) begin
            read_expect($sformatf("ch%0d config", ch), addr_of(ch, `MOTOR_OFF_CONFIG),
                        cfg_data[ch-1]);
            read_expect($sformatf("ch%0d dac_ctrl", ch), addr_of(ch, `MOTOR_OFF_DAC_CTRL),
                        dac_word(dac_data[ch-1][27:24], dac_data[ch-1][15:0]));
            check($sformatf("cur_cmd[%0d]", ch - 1), 32'(dac_data[ch-1][15:0]),
                  32'(cur_cmd[16*(ch-1) +: 16]));
        end
        read_expect("unmapped channel", addr_of(NUM_CH + 1, `MOTOR_OFF_DAC_CTRL), 32'h0);
        read_expect("unmapped offset", addr_of(2, 4'h3), 32'h0);
        // back to reset state, cmd first so fb and cmd agree
        for (int ch = 1; ch <= NUM_CH; ch++) begin
            write_reg(addr_of(ch, `MOTOR_OFF_DAC_CTRL), 32'h0);
            write_reg(addr_of(ch, `MOTOR_OFF_CONFIG), `MOTOR_CONFIG_DEFAULT);
        end
        pulse_clear();
        for (int ch = 1; ch <= NUM_CH; ch++) begin
            read_expect("status restored", addr_of(ch, `MOTOR_OFF_STATUS),
                        status_word(1'b1, 4'h0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 16'h0));
        end
        report_test("test 1 reset and readback", errs);
    endtask

    task automatic control_mode();
        int         errs;
        logic [3:0] mode;
        errs = n_errors;
        for (int k = 0; k < 4; k++) begin
            mode = (k == 3) ? 4'hf : 4'(k);
            write_reg(addr_of(1, `MOTOR_OFF_DAC_CTRL), dac_word(mode, 16'h0));
            read_expect("dac_ctrl mode", addr_of(1, `MOTOR_OFF_DAC_CTRL), dac_word(mode, 16'h0));
            check("cur_ctrl[0]", 32'(mode != 4'h1), 32'(cur_ctrl[0]));
        end
        // voltage mode stored, expander goes away
        write_reg(addr_of(1, `MOTOR_OFF_DAC_CTRL), dac_word(4'h1, 16'h0));
        @(negedge clk);
        ioexp_present = 1'b0;
        #(SETTLE);
        check("cur_ctrl[0] no ioexp", 32'd1, 32'(cur_ctrl[0]));
        write_reg(addr_of(1, `MOTOR_OFF_DAC_CTRL), dac_word(4'h1, 16'h0));
        read_expect("dac_ctrl no ioexp", addr_of(1, `MOTOR_OFF_DAC_CTRL), dac_word(4'h0, 16'h0));
        read_expect("status no ioexp", addr_of(1, `MOTOR_OFF_STATUS),
                    status_word(1'b1, 4'h0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 16'h0));
        check("cur_ctrl[0] no ioexp", 32'd1, 32'(cur_ctrl[0]));
        @(negedge clk);
        ioexp_present = 1'b1;
        report_test("test 2 control mode", errs);
    endtask

    task automatic enable_delay();
        int errs;
        int cycles;
        int min_cyc;
        int max_cyc;
        errs    = n_errors;
        min_cyc = 2 * `DELAY_DIV + 1;    // third tick, earliest alignment
        max_cyc = 3 * `DELAY_DIV;        // third tick, latest alignment
        write_reg(addr_of(1, `MOTOR_OFF_CONFIG), 32'd3);
        @(negedge clk);
        amp_disable[0] = 1'b0;
        cycles = 0;
        do begin
            @(negedge clk);
            #(SETTLE);
            cycles++;
        end while ((amp_disable_pin[0] === 1'b1) && (cycles < 4 * `DELAY_DIV));
        if (amp_disable_pin[0] !== 1'b0) begin
            n_errors++;
            $display("enable delay: amp_disable_pin[0] still high after %0d cycles", cycles);
        end else begin
            check($sformatf("enable delay of %0d cycles within %0d to %0d",
                            cycles, min_cyc, max_cyc), 32'd1,
                  32'((cycles >= min_cyc) && (cycles <= max_cyc)));
        end
        @(negedge clk);
        amp_disable[0] = 1'b1;
        #(SETTLE);
        check("amp_disable_pin[0] rise", 32'd1, 32'(amp_disable_pin[0])); // same cycle
        @(negedge clk);
        ioexp_present  = 1'b0;       // bypass, no delay at all
        amp_disable[0] = 1'b0;
        #(SETTLE);
        check("amp_disable_pin[0] bypass", 32'd0, 32'(amp_disable_pin[0]));
        @(negedge clk);
        amp_disable[0] = 1'b1;
        #(SETTLE);
        check("amp_disable_pin[0] bypass", 32'd1, 32'(amp_disable_pin[0]));
        @(negedge clk);
        ioexp_present = 1'b1;
        write_reg(addr_of(1, `MOTOR_OFF_CONFIG), `MOTOR_CONFIG_DEFAULT);
        report_test("test 3 enable delay", errs);
    endtask

    task automatic latch_on_mismatch();
        int errs;
        errs = n_errors;
        set_fb(2, MID);
        write_reg(addr_of(2, `MOTOR_OFF_DAC_CTRL), dac_word(4'h0, MID));
        reg_raddr = addr_of(2, `MOTOR_OFF_STATUS);
        @(negedge clk);
        set_fb(2, BAD);                  // too short to latch
        repeat (`SAFETY_COUNT - 1) @(negedge clk);
        set_fb(2, MID);
        repeat (4) @(negedge clk);
        #(SETTLE);
        check("status[17] short", 32'd0, 32'(reg_rdata[17]));
        @(negedge clk);
        set_fb(2, MID + `SAFETY_LIMIT);  // at the limit is still fine
        repeat (2 * `SAFETY_COUNT) @(negedge clk);
        set_fb(2, MID);
        #(SETTLE);
        check("status[17] at limit", 32'd0, 32'(reg_rdata[17]));
        @(negedge clk);
        set_fb(2, MID - `SAFETY_LIMIT - 16'd1);
        repeat (`SAFETY_COUNT) @(negedge clk);
        #(SETTLE);
        check("status[17] count", 32'd0, 32'(reg_rdata[17]));
        @(negedge clk);
        set_fb(2, MID);
        #(SETTLE);
        check("status[17] count+1", 32'd1, 32'(reg_rdata[17]));
        repeat (5) @(negedge clk);
        #(SETTLE);
        check("status[17] held", 32'd1, 32'(reg_rdata[17]));
        pulse_clear();
        #(SETTLE);
        check("status[17] cleared", 32'd0, 32'(reg_rdata[17]));
        report_test("test 4 safety latch", errs);
    endtask

    task automatic mask_safety_check();
        int errs;
        errs = n_errors;
        set_fb(3, MID);
        write_reg(addr_of(3, `MOTOR_OFF_DAC_CTRL), dac_word(4'h0, MID));
        for (int k = 0; k < 2; k++) begin
            if (k == 0) begin
                write_reg(addr_of(3, `MOTOR_OFF_CONFIG), `MOTOR_CONFIG_DEFAULT | 32'h0002_0000);
            end else begin
                write_reg(addr_of(3, `MOTOR_OFF_CONFIG), `MOTOR_CONFIG_DEFAULT);
                write_reg(addr_of(3, `MOTOR_OFF_DAC_CTRL), dac_word(4'h1, MID));
                check("cur_ctrl[2] voltage", 32'd0, 32'(cur_ctrl[2]));
            end
            reg_raddr = addr_of(3, `MOTOR_OFF_STATUS);
            set_fb(3, BAD);
            repeat (3 * `SAFETY_COUNT) @(negedge clk);
            set_fb(3, MID);
            #(SETTLE);
            check("status[17] masked", 32'd0, 32'(reg_rdata[17]));
        end
        write_reg(addr_of(3, `MOTOR_OFF_DAC_CTRL), dac_word(4'h0, MID));
        write_reg(addr_of(3, `MOTOR_OFF_CONFIG), `MOTOR_CONFIG_DEFAULT | 32'h0001_0000);
        #(SETTLE);
        check("force_disable_f[2]", 32'd1, 32'(force_disable_f[2]));
        write_reg(addr_of(3, `MOTOR_OFF_CONFIG), `MOTOR_CONFIG_DEFAULT);
        // all combinations of the four status inputs
        for (int v = 0; v < 16; v++) begin
            @(negedge clk);
            amp_disable[2]     = v[0];
            amp_fault[2]       = v[1];
            cur_ctrl_error[2]  = v[2];
            disable_f_error[2] = v[3];
            #(SETTLE);
            check($sformatf("ch3 status %0d", v),
                  status_word(v[0], 4'h0, 1'b1, v[2], v[3], 1'b0, v[1], MID), reg_rdata);
        end
        @(negedge clk);
        amp_disable[2]     = 1'b1;
        amp_fault[2]       = 1'b1;
        cur_ctrl_error[2]  = 1'b0;
        disable_f_error[2] = 1'b0;
        report_test("test 5 safety masking", errs);
    endtask

    initial begin
        clk                = 1'b0;
        rst                = 1'b1;
        reg_waddr          = 16'h0;
        reg_wdata          = 32'h0;
        reg_wen            = 1'b0;
        reg_raddr          = 16'h0;
        ioexp_present      = 1'b1;
        clr_safety_disable = 1'b0;
        amp_fault          = '1;
        cur_ctrl_error     = '0;
        disable_f_error    = '0;
        amp_disable        = '1;      // host keeps every amp off
        cur_fb             = '0;
        seed               = 67;
        n_checks           = 0;
        n_errors           = 0;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        reset_and_readback();
        control_mode();
        enable_delay();
        latch_on_mismatch();
        mask_safety_check();
        $display("%0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/motor_board.sv */
/*
 * Motor section of the amplifier interface board. Instantiates NUM_CHANNELS
 * motor channels (1 to 15), the shared enable delay tick, and the
 * combinational register read mux. Per-channel ports are flat vectors.
 */
`default_nettype none
`include "motor_params.svh"

module motor_board #(
    parameter int NUM_CHANNELS = 4
) (
    input  logic                      clk,
    input  logic                      rst,

    // host register bus
    input  logic [15:0]               reg_waddr,
    input  logic [31:0]               reg_wdata,
    input  logic                      reg_wen,
    input  logic [15:0]               reg_raddr,
    output logic [31:0]               reg_rdata,          // zero latency

    input  logic                      ioexp_present,
    input  logic                      clr_safety_disable, // clears all channels

    // per channel, bit/slice i is channel i+1
    input  logic [NUM_CHANNELS-1:0]    amp_fault,
    input  logic [NUM_CHANNELS-1:0]    cur_ctrl_error,
    input  logic [NUM_CHANNELS-1:0]    disable_f_error,
    input  logic [NUM_CHANNELS-1:0]    amp_disable,
    input  logic [16*NUM_CHANNELS-1:0] cur_fb,
    output logic [NUM_CHANNELS-1:0]    amp_disable_pin,
    output logic [NUM_CHANNELS-1:0]    force_disable_f,
    output logic [NUM_CHANNELS-1:0]    cur_ctrl,
    output logic [16*NUM_CHANNELS-1:0] cur_cmd
);

    logic                  delay_tick;                 // shared by all channels
    logic [31:0]           ch_status [NUM_CHANNELS];
    logic [31:0]           ch_config [NUM_CHANNELS];
    motor_pkg::ctrl_mode_t ch_mode   [NUM_CHANNELS];

    delay_tick_gen u_tick (
        .clk        (clk),
        .rst        (rst),
        .delay_tick (delay_tick)
    );

    for (genvar g = 0; g < NUM_CHANNELS; g++) begin : g_chan
        motor_channel #(
            .CHANNEL (4'(g + 1))
        ) u_chan (
            .clk                (clk),
            .rst                (rst),
            .delay_tick         (delay_tick),
            .reg_waddr          (reg_waddr),
            .reg_wdata          (reg_wdata),
            .reg_wen            (reg_wen),
            .motor_status       (ch_status[g]),
            .motor_config       (ch_config[g]),
            .ioexp_present      (ioexp_present),
            .amp_fault          (amp_fault[g]),
            .cur_ctrl_error     (cur_ctrl_error[g]),
            .disable_f_error    (disable_f_error[g]),
            .amp_disable        (amp_disable[g]),
            .amp_disable_pin    (amp_disable_pin[g]),
            .force_disable_f    (force_disable_f[g]),
            .cur_cmd            (cur_cmd[16*g +: 16]),
            .ctrl_mode          (ch_mode[g]),
            .cur_ctrl           (cur_ctrl[g]),
            .cur_fb             (cur_fb[16*g +: 16]),
            .clr_safety_disable (clr_safety_disable),
            .safety_amp_disable ()       // reported through status bit 17
        );
    end

    // read mux, {main, 0, channel, offset}; unmapped addresses read 0
    always_comb begin
        reg_rdata = 32'd0;
        if ((reg_raddr[15:12] == `MOTOR_ADDR_MAIN) && (reg_raddr[11:8] == 4'd0)) begin
            for (int i = 0; i < NUM_CHANNELS; i++) begin
                if (reg_raddr[7:4] == 4'(i + 1)) begin
                    case (reg_raddr[3:0])
                        `MOTOR_OFF_STATUS:   reg_rdata = ch_status[i];
                        `MOTOR_OFF_DAC_CTRL: reg_rdata = {4'd0, ch_mode[i], 8'd0,
                                                          cur_cmd[16*i +: 16]};
                        `MOTOR_OFF_CONFIG:   reg_rdata = ch_config[i];
                        default:             reg_rdata = 32'd0;
                    endcase
                end
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/motor_channel.sv */
/*
 * One motor channel: decodes its DAC_CTRL and CONFIG writes, holds the command,
 * mode and config registers, builds the status word, and drives the amplifier
 * enable delay and current safety check. CHANNEL is the address nibble.
 */
`default_nettype none
`include "motor_params.svh"

module motor_channel #(
    parameter logic [3:0] CHANNEL = 4'd1       // channel nibble of the address
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  delay_tick,          // from delay_tick_gen

    // host register write port
    input  logic [15:0]           reg_waddr,
    input  logic [31:0]           reg_wdata,
    input  logic                  reg_wen,
    output logic [31:0]           motor_status,
    output logic [31:0]           motor_config,

    input  logic                  ioexp_present,       // I/O expander fitted

    // amplifier control and feedback
    input  logic                  amp_fault,           // 0 -> fault when enabled
    input  logic                  cur_ctrl_error,      // cur_ctrl pin mismatch
    input  logic                  disable_f_error,     // disable_f pin mismatch
    input  logic                  amp_disable,         // host request
    output logic                  amp_disable_pin,
    output logic                  force_disable_f,     // 1 -> follower amp on

    output motor_pkg::current_t   cur_cmd,             // commanded current/voltage
    output motor_pkg::ctrl_mode_t ctrl_mode,
    output logic                  cur_ctrl,            // 1 current, 0 voltage

    input  motor_pkg::current_t   cur_fb,              // measured current
    input  logic                  clr_safety_disable,
    output logic                  safety_amp_disable
);

    localparam logic [15:0] ADDR_DAC_CTRL =
        {`MOTOR_ADDR_MAIN, 4'd0, CHANNEL, `MOTOR_OFF_DAC_CTRL};
    localparam logic [15:0] ADDR_CONFIG =
        {`MOTOR_ADDR_MAIN, 4'd0, CHANNEL, `MOTOR_OFF_CONFIG};

    logic       dac_wen;          // write strobe hits DAC_CTRL
    logic       cfg_wen;          // write strobe hits CONFIG
    logic       disable_safety;
    logic       amp_fault_fb;
    logic [7:0] delay_cnt;        // enable delay, in ticks

    assign dac_wen = reg_wen && (reg_waddr == ADDR_DAC_CTRL);
    assign cfg_wen = reg_wen && (reg_waddr == ADDR_CONFIG);

    // command and mode
    always_ff @(posedge clk) begin
        if (rst) begin
            cur_cmd   <= '0;
            ctrl_mode <= motor_pkg::CTRL_CURRENT;
        end else if (dac_wen) begin
            cur_cmd <= reg_wdata[15:0];
            // only current control without the I/O expander
            if (ioexp_present) begin
                ctrl_mode <= motor_pkg::ctrl_mode_t'(reg_wdata[27:24]);
            end else begin
                ctrl_mode <= motor_pkg::CTRL_CURRENT;
            end
        end
    end

    // configuration word
    always_ff @(posedge clk) begin
        if (rst) begin
            motor_config <= `MOTOR_CONFIG_DEFAULT;
        end else if (cfg_wen) begin
            motor_config <= reg_wdata;
        end
    end

    assign force_disable_f = motor_config[`MOTOR_CFG_FORCE_DISABLE_F];
    assign disable_safety  = motor_config[`MOTOR_CFG_DISABLE_SAFETY];
    assign delay_cnt       = motor_config[`MOTOR_CFG_DELAY_MSB:0];

    // voltage mode needs mode 1 and the expander, everything else is current
    assign cur_ctrl = !(ioexp_present && (ctrl_mode == motor_pkg::CTRL_VOLTAGE));

    // enabled but amp reports fault
    assign amp_fault_fb = ~(amp_disable | amp_fault);

    assign motor_status = {3'b000, ~amp_disable, ctrl_mode, 3'b000, cur_ctrl,
                           cur_ctrl_error, disable_f_error, safety_amp_disable,
                           amp_fault_fb, cur_cmd};

    amp_enable_delay u_enable_delay (
        .clk             (clk),
        .rst             (rst),
        .delay_tick      (delay_tick),
        .amp_disable     (amp_disable),
        .bypass          (~ioexp_present),   // old boards cannot delay
        .delay_cnt       (delay_cnt),
        .amp_disable_pin (amp_disable_pin)
    );

    safety_check u_safety (
        .clk           (clk),
        .rst           (rst),
        .cur_in        (cur_fb),
        .dac_in        (cur_cmd),
        .enable_check  (~disable_safety & cur_ctrl),  // no check in voltage mode
        .clear_disable (clr_safety_disable),
        .amp_disable   (safety_amp_disable)
    );

    a_mode_needs_ioexp: assert property (@(posedge clk) disable iff (rst)
        (dac_wen && !ioexp_present) |=> (ctrl_mode == motor_pkg::CTRL_CURRENT));

endmodule

`default_nettype wire

/* rtl/safety_check.sv */
/*
 * Current safety check for one channel. Compares measured current against the
 * commanded value and latches an amplifier disable when the difference stays
 * above SAFETY_LIMIT for SAFETY_COUNT cycles. Host clears via clear_disable.
 */
`default_nettype none
`include "motor_params.svh"

module safety_check (
    input  logic                clk,
    input  logic                rst,
    input  motor_pkg::current_t cur_in,        // measured current
    input  motor_pkg::current_t dac_in,        // commanded current
    input  logic                enable_check,  // 0 -> never flag
    input  logic                clear_disable, // host clear, wins over set
    output logic                amp_disable    // latched safety disable
);

    localparam int CNT_W = $clog2(`SAFETY_COUNT + 1);

    motor_pkg::current_t cur_diff;    // |cur_in - dac_in|
    logic                over_limit;
    logic [CNT_W-1:0]    err_cnt;     // consecutive over-limit cycles
    logic                err_full;

    // both words are offset binary, so a plain unsigned compare works
    always_comb begin
        if (cur_in > dac_in) begin
            cur_diff = cur_in - dac_in;
        end else begin
            cur_diff = dac_in - cur_in;
        end
    end

    assign over_limit = enable_check && (cur_diff > `SAFETY_LIMIT);
    assign err_full   = (err_cnt == CNT_W'(`SAFETY_COUNT));

    // counter saturates at SAFETY_COUNT, any good cycle restarts it
    always_ff @(posedge clk) begin
        if (rst) begin
            err_cnt <= '0;
        end else if (!over_limit) begin
            err_cnt <= '0;
        end else if (!err_full) begin
            err_cnt <= err_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            amp_disable <= 1'b0;
        end else if (clear_disable) begin
            amp_disable <= 1'b0;          // clear has priority
        end else if (err_full) begin
            amp_disable <= 1'b1;          // SAFETY_COUNT+1 cycles after onset
        end
    end

    a_cnt_bounded: assert property (@(posedge clk) disable iff (rst)
        err_cnt <= CNT_W'(`SAFETY_COUNT));

endmodule

`default_nettype wire

/* rtl/amp_enable_delay.sv */
/*
 * Delays the amplifier enable (falling amp_disable) by delay_cnt ticks so the
 * follower stage can settle. Disables always pass straight through.
 */
`default_nettype none

module amp_enable_delay (
    input  logic       clk,
    input  logic       rst,
    input  logic       delay_tick,      // slow step enable
    input  logic       amp_disable,     // host request, 1 -> disabled
    input  logic       bypass,          // 1 -> no delay (no I/O expander)
    input  logic [7:0] delay_cnt,       // programmed delay in ticks
    output logic       amp_disable_pin  // drives the FPGA pin
);

    logic [7:0] enable_cnt;   // ticks since enable requested
    logic       delay_done;

    always_ff @(posedge clk) begin
        if (rst) begin
            enable_cnt <= 8'd0;
        end else if (amp_disable) begin
            enable_cnt <= 8'd0;           // restart on every disable
        end else if (delay_tick && (enable_cnt != delay_cnt)) begin
            enable_cnt <= enable_cnt + 8'd1;
        end
    end

    assign delay_done = (enable_cnt == delay_cnt);

    // only the enable edge is held back, a disable takes effect at once
    assign amp_disable_pin = (delay_done || bypass) ? amp_disable : 1'b1;

    // host disable must never be masked by the delay logic
    a_disable_passes: assert property (@(posedge clk) disable iff (rst)
        amp_disable |-> amp_disable_pin);

endmodule

`default_nettype wire

/* rtl/delay_tick_gen.sv */
/*
 * Divides clk down to a single-cycle enable tick, one every DELAY_DIV cycles.
 * Replaces a separate slow clock for the amplifier enable delay counters.
 */
`default_nettype none
`include "motor_params.svh"

module delay_tick_gen (
    input  logic clk,
    input  logic rst,
    output logic delay_tick     // one clk wide, every DELAY_DIV cycles
);

    localparam int CNT_W = (`DELAY_DIV > 1) ? $clog2(`DELAY_DIV) : 1;

    logic [CNT_W-1:0] div_cnt;  // free running divider

    always_ff @(posedge clk) begin
        if (rst) begin
            div_cnt    <= '0;
            delay_tick <= 1'b0;
        end else if (div_cnt == CNT_W'(`DELAY_DIV - 1)) begin
            div_cnt    <= '0;
            delay_tick <= 1'b1;   // first tick DELAY_DIV cycles after reset
        end else begin
            div_cnt    <= div_cnt + 1'b1;
            delay_tick <= 1'b0;
        end
    end

    // tick must stay a pulse so every counter step is one tick
    a_tick_pulse: assert property (@(posedge clk) disable iff (rst)
        delay_tick |=> !delay_tick);

endmodule

`default_nettype wire

/* rtl/motor_pkg.sv */
/*
 * Types shared by the motor channel RTL and its testbench.
 * Referenced by scoped name, e.g. motor_pkg::current_t.
 */
`default_nettype none

package motor_pkg;

    // control mode as written in DAC_CTRL bits 27:24
    // values other than the two below are treated as current control
    typedef enum logic [3:0] {
        CTRL_CURRENT = 4'd0,   // closed loop on current
        CTRL_VOLTAGE = 4'd1    // open loop voltage drive, needs I/O expander
    } ctrl_mode_t;

    // offset-binary DAC / ADC word, mid scale is zero current
    typedef logic [15:0] current_t;

endpackage

`default_nettype wire

/* include/motor_params.svh */
/*
 * Shared constants for the motor channel block: register map, configuration
 * defaults, current safety limits and the enable delay tick divider.
 * Include wherever an address or limit is needed.
 */
`ifndef MOTOR_PARAMS_SVH
`define MOTOR_PARAMS_SVH

// register address = {main, 4'h0, channel, offset}
`define MOTOR_ADDR_MAIN        4'd4     // top nibble, motor register space
`define MOTOR_OFF_STATUS       4'd0     // read only status word
`define MOTOR_OFF_DAC_CTRL     4'd1     // command word plus control mode
`define MOTOR_OFF_CONFIG       4'd2     // channel configuration word

// configuration word fields
`define MOTOR_CFG_DISABLE_SAFETY   17   // 1 -> skip current safety check
`define MOTOR_CFG_FORCE_DISABLE_F  16   // 1 -> follower amp forced on
`define MOTOR_CFG_DELAY_MSB        7    // delay field is [7:0]
`define MOTOR_CONFIG_DEFAULT   32'd20   // delay of 20 ticks, all flags clear

// current safety check
`define SAFETY_LIMIT           16'd800  // max |fb - cmd| in DAC counts
`define SAFETY_COUNT           8        // consecutive bad cycles before latch

// clk cycles per enable delay tick
`define DELAY_DIV              16

`endif
